//--- design/numbat_config.svh
`ifndef NUMBAT_CONFIG_SVH
`define NUMBAT_CONFIG_SVH

// whole position, 64 squares of one piece code each
`define BOARD_WIDTH 256

// one piece code, bit 3 carries the colour
`define PIECE_WIDTH 4

// bits per board row, eight squares
`define SIDE_WIDTH 32

// packed UCI move as laid out in chess_pkg::uci_t
`define UCI_WIDTH 16

// 8 rows of 17 characters plus the 7-character status line
`define DISPLAY_CHARS 143

`endif

//--- design/chess_pkg.sv
`default_nettype none
`include "numbat_config.svh"

package chess_pkg;

   typedef enum logic [`PIECE_WIDTH-1:0]
   {
      piece_empty  = 4'd0,
      white_pawn   = 4'd1,
      white_rook   = 4'd2,
      white_knight = 4'd3,
      white_bishop = 4'd4,
      white_king   = 4'd5,
      white_queen  = 4'd6,
      black_pawn   = 4'd9,
      black_rook   = 4'd10,
      black_knight = 4'd11,
      black_bishop = 4'd12,
      black_king   = 4'd13,
      black_queen  = 4'd14
   } piece_t;

   // piece kind without colour, the low three bits of a piece_t
   typedef enum logic [2:0]
   {
      kind_none   = 3'd0,
      kind_pawn   = 3'd1,
      kind_rook   = 3'd2,
      kind_knight = 3'd3,
      kind_bishop = 3'd4,
      kind_king   = 3'd5,
      kind_queen  = 3'd6
   } kind_t;

   typedef logic [5:0] square_t; // row * 8 + column, row 0 is white's back rank

   typedef struct packed
   {
      piece_t     promotion; // colour bit ignored, empty when not promoting
      logic [2:0] to_row;
      logic [2:0] to_col;
      logic [2:0] from_row;
      logic [2:0] from_col;
   } uci_t;

   function automatic kind_t piece_kind(input piece_t p);
      return kind_t'(p[2:0]);
   endfunction

   function automatic logic piece_is_black(input piece_t p);
      return p[`PIECE_WIDTH-1];
   endfunction

   function automatic piece_t make_piece(input kind_t k, input logic black);
      return piece_t'({black, k});
   endfunction

   function automatic kind_t back_rank_kind(input logic [2:0] col);
      case (col)
         3'd0, 3'd7: return kind_rook;
         3'd1, 3'd6: return kind_knight;
         3'd2, 3'd5: return kind_bishop;
         3'd3:       return kind_queen;
         default:    return kind_king;
      endcase
   endfunction

endpackage

`default_nettype wire

//--- design/board_state.sv
`default_nettype none
`include "numbat_config.svh"

module board_state
   (
      input wire                      clk,
      input wire                      reset,
      input wire                      load_start,
      input wire                      move_valid,
      input wire chess_pkg::uci_t     uci,
      output logic [`BOARD_WIDTH-1:0] board,
      output logic [3:0]              castle_mask, // {K, Q, k, q}
      output logic                    capture
   );

   localparam chess_pkg::square_t sq_a1 = 6'd0;
   localparam chess_pkg::square_t sq_h1 = 6'd7;
   localparam chess_pkg::square_t sq_a8 = 6'd56;
   localparam chess_pkg::square_t sq_h8 = 6'd63;

   function automatic logic [`BOARD_WIDTH-1:0] start_position();
      logic [`BOARD_WIDTH-1:0] b;
      b = '0;
      for (int c = 0; c < 8; c++)
      begin
         b[c * `PIECE_WIDTH +: `PIECE_WIDTH] =
            chess_pkg::make_piece(chess_pkg::back_rank_kind(3'(c)), 1'b0);
         b[(8 + c) * `PIECE_WIDTH +: `PIECE_WIDTH] =
            chess_pkg::make_piece(chess_pkg::kind_pawn, 1'b0);
         b[(48 + c) * `PIECE_WIDTH +: `PIECE_WIDTH] =
            chess_pkg::make_piece(chess_pkg::kind_pawn, 1'b1);
         b[(56 + c) * `PIECE_WIDTH +: `PIECE_WIDTH] =
            chess_pkg::make_piece(chess_pkg::back_rank_kind(3'(c)), 1'b1);
      end
      return b;
   endfunction

   localparam logic [`BOARD_WIDTH-1:0] start_board = start_position();

   chess_pkg::square_t      from_sq, to_sq, ep_sq, rook_from_sq, rook_to_sq;
   chess_pkg::piece_t       mover, target, placed, rook;
   logic                    mover_black, is_pawn, is_king;
   logic                    en_passant, castling, king_side;
   logic signed [3:0]       col_delta;
   logic [`BOARD_WIDTH-1:0] next_board;
   logic [3:0]              next_mask;

   assign from_sq = {uci.from_row, uci.from_col};
   assign to_sq   = {uci.to_row, uci.to_col};
   assign ep_sq   = {uci.from_row, uci.to_col}; // the pawn being passed sits beside the mover

   assign mover  = chess_pkg::piece_t'(board[from_sq * `PIECE_WIDTH +: `PIECE_WIDTH]);
   assign target = chess_pkg::piece_t'(board[to_sq * `PIECE_WIDTH +: `PIECE_WIDTH]);

   assign mover_black = chess_pkg::piece_is_black(mover);
   assign is_pawn     = chess_pkg::piece_kind(mover) == chess_pkg::kind_pawn;
   assign is_king     = chess_pkg::piece_kind(mover) == chess_pkg::kind_king;
   assign col_delta   = $signed({1'b0, uci.to_col}) - $signed({1'b0, uci.from_col});

   assign en_passant = is_pawn && (uci.from_col != uci.to_col)
                       && (target == chess_pkg::piece_empty);
   assign castling   = is_king && (col_delta == 4'sd2 || col_delta == -4'sd2);
   assign king_side  = col_delta > 4'sd0;

   // rook leaves its corner and lands on the square the king crossed
   assign rook_from_sq = {uci.from_row, king_side ? 3'd7 : 3'd0};
   assign rook_to_sq   = {uci.from_row, king_side ? uci.from_col + 3'd1 : uci.from_col - 3'd1};
   assign rook = chess_pkg::piece_t'(board[rook_from_sq * `PIECE_WIDTH +: `PIECE_WIDTH]);

   assign placed = (is_pawn && uci.promotion != chess_pkg::piece_empty)
                   ? chess_pkg::make_piece(chess_pkg::piece_kind(uci.promotion), mover_black)
                   : mover;

   always_comb
   begin
      next_board = board;
      next_board[from_sq * `PIECE_WIDTH +: `PIECE_WIDTH] = '0;
      next_board[to_sq * `PIECE_WIDTH +: `PIECE_WIDTH] = placed;
      if (en_passant)
         next_board[ep_sq * `PIECE_WIDTH +: `PIECE_WIDTH] = '0;
      if (castling)
      begin
         next_board[rook_from_sq * `PIECE_WIDTH +: `PIECE_WIDTH] = '0;
         next_board[rook_to_sq * `PIECE_WIDTH +: `PIECE_WIDTH] = rook;
      end
   end

   always_comb
   begin
      next_mask = castle_mask;
      if (is_king)
      begin
         if (mover_black)
            next_mask[1:0] = 2'b00;
         else
            next_mask[3:2] = 2'b00;
      end
      // anything leaving or landing on a corner ends that rook's right
      if (from_sq == sq_h1 || to_sq == sq_h1)
         next_mask[3] = 1'b0;
      if (from_sq == sq_a1 || to_sq == sq_a1)
         next_mask[2] = 1'b0;
      if (from_sq == sq_h8 || to_sq == sq_h8)
         next_mask[1] = 1'b0;
      if (from_sq == sq_a8 || to_sq == sq_a8)
         next_mask[0] = 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         board       <= '0;
         castle_mask <= 4'b0000;
         capture     <= 1'b0;
      end
      else if (load_start) // load wins over a move in the same cycle
      begin
         board       <= start_board;
         castle_mask <= 4'b1111;
         capture     <= 1'b0;
      end
      else if (move_valid)
      begin
         board       <= next_board;
         castle_mask <= next_mask;
         capture     <= (target != chess_pkg::piece_empty) || en_passant;
      end
   end

   a_move_from_occupied: assert property (@(posedge clk) disable iff (reset)
      move_valid && !load_start |-> mover != chess_pkg::piece_empty)
      else $error("move issued from an empty square");

   a_castle_target_col: assert property (@(posedge clk) disable iff (reset)
      move_valid && !load_start && castling |-> uci.to_col inside {3'd2, 3'd6})
      else $error("castling king landed outside columns c and g");

endmodule

`default_nettype wire

//--- design/display_board.sv
`default_nettype none
`include "numbat_config.svh"

module display_board
   (
      input wire                    clk,
      input wire                    reset,
      input wire [`BOARD_WIDTH-1:0] board,
      input wire [3:0]              castle_mask,
      input wire                    capture,
      input wire                    display,
      output logic                  char_valid,
      output logic [7:0]            char_data,
      output logic                  display_done
   );

   localparam int idx_w = $clog2(`BOARD_WIDTH);
   localparam int cnt_w = $clog2(`DISPLAY_CHARS + 1);
   localparam logic [idx_w-1:0] piece_step = idx_w'(`PIECE_WIDTH);
   localparam logic [idx_w-1:0] row_step   = idx_w'(`SIDE_WIDTH);
   localparam logic [idx_w-1:0] top_row    = idx_w'(`SIDE_WIDTH * 7);

   typedef enum logic [1:0] {st_idle, st_row, st_status} state_t;
   typedef enum logic [1:0] {ph_piece, ph_space, ph_newline} phase_t;

   state_t                  state;
   phase_t                  phase;      // kind of the next character in a row
   logic [`BOARD_WIDTH-1:0] snap_board;
   logic [3:0]              snap_mask;
   logic                    snap_capture;
   logic [idx_w-1:0]        row_start, index;
   logic [2:0]              col;
   logic [2:0]              stat_idx;
   logic [cnt_w-1:0]        sent;

   function automatic logic [7:0] piece_char(input chess_pkg::piece_t p);
      case (p)
         chess_pkg::piece_empty:  return ".";
         chess_pkg::white_pawn:   return "P";
         chess_pkg::white_rook:   return "R";
         chess_pkg::white_knight: return "N";
         chess_pkg::white_bishop: return "B";
         chess_pkg::white_king:   return "K";
         chess_pkg::white_queen:  return "Q";
         chess_pkg::black_pawn:   return "p";
         chess_pkg::black_rook:   return "r";
         chess_pkg::black_knight: return "n";
         chess_pkg::black_bishop: return "b";
         chess_pkg::black_king:   return "k";
         chess_pkg::black_queen:  return "q";
         default:                 return "?";
      endcase
   endfunction

   function automatic logic [7:0] status_char(input logic [2:0] i, input logic [3:0] mask,
                                              input logic cap);
      case (i)
         3'd0:    return mask[3] ? "K" : "-";
         3'd1:    return mask[2] ? "Q" : "-";
         3'd2:    return mask[1] ? "k" : "-";
         3'd3:    return mask[0] ? "q" : "-";
         3'd4:    return " ";
         3'd5:    return cap ? "x" : "-";
         default: return "\n";
      endcase
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state        <= st_idle;
         char_valid   <= 1'b0;
         display_done <= 1'b0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               char_valid   <= 1'b0;
               display_done <= 1'b0;
               if (display && !display_done)
               begin
                  snap_board   <= board;
                  snap_mask    <= castle_mask;
                  snap_capture <= capture;
                  // first square goes out straight from the live board
                  char_data  <= piece_char(chess_pkg::piece_t'(board[top_row +: `PIECE_WIDTH]));
                  char_valid <= 1'b1;
                  row_start  <= top_row;
                  index      <= top_row + piece_step;
                  col        <= 3'd0;
                  phase      <= ph_space;
                  state      <= st_row;
               end
            end
            st_row:
            begin
               case (phase)
                  ph_piece:
                  begin
                     char_data <= piece_char(chess_pkg::piece_t'(snap_board[index +: `PIECE_WIDTH]));
                     index     <= index + piece_step;
                     phase     <= ph_space;
                  end
                  ph_space:
                  begin
                     char_data <= " ";
                     if (col == 3'd7)
                        phase <= ph_newline;
                     else
                     begin
                        col   <= col + 3'd1;
                        phase <= ph_piece;
                     end
                  end
                  default:
                  begin
                     char_data <= "\n";
                     if (row_start == '0) // row 0 done, status line follows
                     begin
                        stat_idx <= 3'd0;
                        state    <= st_status;
                     end
                     else
                     begin
                        row_start <= row_start - row_step;
                        index     <= row_start - row_step;
                        col       <= 3'd0;
                        phase     <= ph_piece;
                     end
                  end
               endcase
            end
            st_status:
            begin
               if (stat_idx == 3'd7)
               begin
                  char_valid   <= 1'b0;
                  display_done <= 1'b1;
                  state        <= st_idle;
               end
               else
               begin
                  char_data <= status_char(stat_idx, snap_mask, snap_capture);
                  stat_idx  <= stat_idx + 3'd1;
               end
            end
            default:
               state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || display_done)
         sent <= '0;
      else if (char_valid)
         sent <= sent + 1'b1;
   end

   a_valid_done_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(char_valid && display_done))
      else $error("char_valid and display_done high together");

   a_done_then_idle: assert property (@(posedge clk) disable iff (reset)
      display_done |=> !char_valid && !display_done)
      else $error("no idle cycle after display_done");

   a_char_count: assert property (@(posedge clk) disable iff (reset)
      display_done |-> sent == cnt_w'(`DISPLAY_CHARS))
      else $error("walk emitted %0d characters", sent);

endmodule

`default_nettype wire

//--- design/numbat_board_top.sv
`default_nettype none
`include "numbat_config.svh"

module numbat_board_top
   (
      input wire                  clk,
      input wire                  reset,
      input wire                  load_start,
      input wire                  move_valid,
      input wire chess_pkg::uci_t uci,
      input wire                  display,
      output wire                 char_valid,
      output wire [7:0]           char_data,
      output wire                 display_done,
      output wire [3:0]           castle_mask,
      output wire                 capture
   );

   wire [`BOARD_WIDTH-1:0] position; // current board, one piece code per square

   board_state u_board_state
   (
      .clk         (clk),
      .reset       (reset),
      .load_start  (load_start),
      .move_valid  (move_valid),
      .uci         (uci),
      .board       (position),
      .castle_mask (castle_mask),
      .capture     (capture)
   );

   display_board u_display_board
   (
      .clk          (clk),
      .reset        (reset),
      .board        (position),
      .castle_mask  (castle_mask),
      .capture      (capture),
      .display      (display),
      .char_valid   (char_valid),
      .char_data    (char_data),
      .display_done (display_done)
   );

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
`default_nettype none
`include "numbat_config.svh"

module tb_checker
   (
      input wire                  clk,
      input wire                  reset,
      input wire                  load_start,
      input wire                  move_valid,
      input wire [`UCI_WIDTH-1:0] uci,
      input wire                  display,
      input wire                  char_valid,
      input wire [7:0]            char_data,
      input wire                  display_done,
      input wire [3:0]            castle_mask,
      input wire                  capture,
      output int                  test_count,
      output int                  fail_count
   );
   timeunit 1ns;
   timeprecision 100ps;

   localparam int max_reports = 4;
   localparam string glyphs = ".PRNBKQ??prnbkq?"; // indexed by the piece code
   // white back rank from the a-file while black adds the colour bit
   localparam logic [3:0] back_codes [8] = '{4'd2, 4'd3, 4'd4, 4'd6, 4'd5, 4'd4, 4'd3, 4'd2};

   logic [3:0] sq [64];
   logic [3:0] model_mask;
   logic       model_capture;
   byte        expected [`DISPLAY_CHARS];
   bit         busy;
   int         received;
   int         errors;
   int         elapsed;

   task automatic load_model();
      for (int c = 0; c < 8; c++)
      begin
         sq[c]      = back_codes[c];
         sq[8 + c]  = 4'd1;
         sq[48 + c] = 4'd9;
         sq[56 + c] = back_codes[c] | 4'd8;
         for (int r = 2; r < 6; r++)
            sq[r * 8 + c] = 4'd0;
      end
      model_mask    = 4'hf;
      model_capture = 1'b0;
   endtask

   task automatic apply_move(input logic [`UCI_WIDTH-1:0] m);
      int         fc, fr, tc, tr, from, to;
      logic [3:0] p, t, promo, placed;
      bit         ep;
      fc    = int'(m[2:0]);
      fr    = int'(m[5:3]);
      tc    = int'(m[8:6]);
      tr    = int'(m[11:9]);
      promo = m[15:12];
      from  = fr * 8 + fc;
      to    = tr * 8 + tc;
      p     = sq[from];
      t     = sq[to];
      ep    = (p[2:0] == 3'd1) && (fc != tc) && (t == 4'd0);
      placed = (p[2:0] == 3'd1 && promo != 4'd0) ? {p[3], promo[2:0]} : p;
      sq[from] = 4'd0;
      sq[to]   = placed;
      if (ep)
         sq[fr * 8 + tc] = 4'd0; // the passed pawn stands beside the mover
      if (p[2:0] == 3'd5 && (tc - fc == 2 || fc - tc == 2))
      begin
         if (tc > fc)
         begin
            sq[fr * 8 + fc + 1] = sq[fr * 8 + 7];
            sq[fr * 8 + 7]      = 4'd0;
         end
         else
         begin
            sq[fr * 8 + fc - 1] = sq[fr * 8];
            sq[fr * 8]          = 4'd0;
         end
      end
      if (p[2:0] == 3'd5)
      begin
         if (p[3])
            model_mask[1:0] = 2'b00;
         else
            model_mask[3:2] = 2'b00;
      end
      if (from == 7 || to == 7)
         model_mask[3] = 1'b0;
      if (from == 0 || to == 0)
         model_mask[2] = 1'b0;
      if (from == 63 || to == 63)
         model_mask[1] = 1'b0;
      if (from == 56 || to == 56)
         model_mask[0] = 1'b0;
      model_capture = (t != 4'd0) || ep;
   endtask

   task automatic start_test();
      int n;
      n        = 0;
      busy     = 1'b1;
      received = 0;
      errors   = 0;
      elapsed  = 0;
      if (castle_mask !== model_mask)
      begin
         $display("ERR test %0d castle_mask: expected %h got %h", test_count + 1, model_mask,
                  castle_mask);
         errors++;
      end
      if (capture !== model_capture)
      begin
         $display("ERR test %0d capture: expected %h got %h", test_count + 1, model_capture,
                  capture);
         errors++;
      end
      for (int r = 7; r >= 0; r--)
      begin
         for (int c = 0; c < 8; c++)
         begin
            expected[n]     = glyphs[sq[r * 8 + c]];
            expected[n + 1] = " ";
            n += 2;
         end
         expected[n] = "\n";
         n++;
      end
      expected[n]     = model_mask[3] ? "K" : "-";
      expected[n + 1] = model_mask[2] ? "Q" : "-";
      expected[n + 2] = model_mask[1] ? "k" : "-";
      expected[n + 3] = model_mask[0] ? "q" : "-";
      expected[n + 4] = " ";
      expected[n + 5] = model_capture ? "x" : "-";
      expected[n + 6] = "\n";
   endtask

   task automatic finish_test();
      if (received != `DISPLAY_CHARS)
      begin
         $display("test %0d: the walk sent %0d characters instead of %0d", test_count + 1,
                  received, `DISPLAY_CHARS);
         errors++;
      end
      // characters run back to back, so done lands one cycle after the last of them
      if (elapsed != `DISPLAY_CHARS + 1)
      begin
         $display("test %0d: display_done came %0d cycles after the display pulse instead of %0d",
                  test_count + 1, elapsed, `DISPLAY_CHARS + 1);
         errors++;
      end
      if (errors == 0)
         $display("PASS test %0d", test_count + 1);
      else
      begin
         $display("FAIL test %0d with %0d errors", test_count + 1, errors);
         fail_count++;
      end
      test_count++;
      busy = 1'b0;
   endtask

   // outputs read here are the values registered on the previous edge
   always @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < 64; i++)
            sq[i] = 4'd0;
         model_mask    = 4'h0;
         model_capture = 1'b0;
         busy          = 1'b0;
         test_count    = 0;
         fail_count    = 0;
      end
      else
      begin
         if (busy)
            elapsed++;
         if (char_valid && !busy)
         begin
            $display("a character arrived outside any display walk");
            fail_count++;
         end
         else if (char_valid)
         begin
            if (received < `DISPLAY_CHARS && char_data !== expected[received])
            begin
               errors++;
               if (errors <= max_reports)
                  $display("ERR test %0d char_data[%0d]: expected %h got %h", test_count + 1,
                           received, expected[received], char_data);
            end
            received++;
         end
         if (display_done && !busy)
         begin
            $display("display_done pulsed without a display walk");
            fail_count++;
         end
         else if (display_done)
            finish_test();
         if (display && !busy && !display_done)
            start_test();
         if (load_start)
            load_model();
         else if (move_valid)
            apply_move(uci);
      end
   end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
`default_nettype none
`include "numbat_config.svh"

module tb_top;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int reset_cycles = 16;
   localparam int cycles_per_case = 200; // a full walk is 144 cycles plus gaps
   localparam logic [31:0] seed = 32'h0833ec90;
   localparam string case_file = "verif/display_cases.txt";

   logic                  clk = 1'b0;
   logic                  reset = 1'b1;
   logic                  load_start = 1'b0;
   logic                  move_valid = 1'b0;
   logic                  display = 1'b0;
   logic [`UCI_WIDTH-1:0] uci = '0;
   wire                   char_valid;
   wire [7:0]             char_data;
   wire                   display_done;
   wire [3:0]             castle_mask;
   wire                   capture;
   int                    test_count;
   int                    fail_count;

   byte                   cmd_q[$];
   logic [`UCI_WIDTH-1:0] uci_q[$];
   int                    gap_q[$];
   int                    cycle_limit = 0;
   int                    cycle_count = 0;
   logic [31:0]           rng_state = seed;

   always #5 clk = ~clk;

   numbat_board_top DUT
   (
      .clk          (clk),
      .reset        (reset),
      .load_start   (load_start),
      .move_valid   (move_valid),
      .uci          (uci),
      .display      (display),
      .char_valid   (char_valid),
      .char_data    (char_data),
      .display_done (display_done),
      .castle_mask  (castle_mask),
      .capture      (capture)
   );

   tb_checker u_checker
   (
      .clk          (clk),
      .reset        (reset),
      .load_start   (load_start),
      .move_valid   (move_valid),
      .uci          (uci),
      .display      (display),
      .char_valid   (char_valid),
      .char_data    (char_data),
      .display_done (display_done),
      .castle_mask  (castle_mask),
      .capture      (capture),
      .test_count   (test_count),
      .fail_count   (fail_count)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // lines that do not start with a command letter are skipped
   function automatic bit read_cases();
      int                    fd;
      int                    n;
      string                 line;
      byte                   c;
      logic [`UCI_WIDTH-1:0] v;
      int                    g;
      fd = $fopen(case_file, "r");
      if (fd == 0)
         return 1'b0;
      while ($fgets(line, fd) > 0)
      begin
         n = $sscanf(line, "%c %h %d", c, v, g);
         if (n == 3 && (c == "L" || c == "M" || c == "D"))
         begin
            cmd_q.push_back(c);
            uci_q.push_back(v);
            gap_q.push_back(g);
         end
      end
      $fclose(fd);
      return 1'b1;
   endfunction

   task automatic apply_command(input byte c, input logic [`UCI_WIDTH-1:0] v);
      @(negedge clk);
      load_start = (c == "L");
      move_valid = (c == "M");
      display    = (c == "D");
      uci        = v;
      @(negedge clk);
      load_start = 1'b0;
      move_valid = 1'b0;
      display    = 1'b0;
   endtask

   task automatic wait_display_done();
      do
         @(negedge clk);
      while (display_done !== 1'b1);
   endtask

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_limit != 0 && cycle_count > cycle_limit)
      begin
         $display("timeout: display never completed");
         $display("Simulation failed");
         $finish;
      end
   end

   initial
   begin
      bit ok;
      int gap;
      int expected_walks;
      expected_walks = 0;
      ok = read_cases();
      if (!ok)
      begin
         $display("could not open %s", case_file);
         $display("Simulation failed");
         $finish;
      end
      else
      begin
         cycle_limit = reset_cycles + cmd_q.size() * cycles_per_case;
         repeat (reset_cycles) @(negedge clk);
         reset = 1'b0;
         for (int i = 0; i < cmd_q.size(); i++)
         begin
            apply_command(cmd_q[i], uci_q[i]);
            if (cmd_q[i] == "D" && uci_q[i] == '0) // a nonzero value leaves the walk running
            begin
               expected_walks++;
               wait_display_done();
            end
            gap = gap_q[i];
            if (gap == 0)
            begin
               rng_state = xorshift(rng_state);
               gap = 1 + int'(rng_state % 32'd4);
            end
            repeat (gap - 1) @(negedge clk);
         end
         repeat (4) @(negedge clk);
         $display("tests %0d, passed %0d, failed %0d", test_count,
                  test_count - fail_count, fail_count);
         if (fail_count == 0 && test_count == expected_walks)
            $display("Simulation passed");
         else
         begin
            if (test_count != expected_walks)
               $display("expected %0d completed displays but saw %0d", expected_walks,
                        test_count);
            $display("Simulation failed");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- verif/display_cases.txt
# columns: command (L load, M move, D display), uci in hex, idle gap in cycles (0 = random 1..4)
# uci for D: 0 waits for display_done, 1 leaves the walk running for the following lines
D 0000 2
L 0000 0
D 0000 0
M 070C 0
M 08F3 0
M 08DC 1
D 0000 0
M 08FB 0
M 0546 0
D 0000 3
M 0AB9 0
M 0685 0
M 097A 0
M 0184 0
M 0B34 0
M 05CF 0
M 0EBC 0
D 0000 0
L 0000 2
M 0608 0
M 09F7 0
M 0400 0
M 0BFF 0
D 0000 0
M 050C 0
M 0304 0
D 0000 1
L 0000 0
M 06CB 0
M 0BB6 0
M 0481 0
M 0DBD 0
M 0742 0
M 0B7E 0
M 02C3 0
M 0FBC 0
M 0084 0
D 0000 0
L 0000 0
M 070C 0
M 0A30 0
M 091C 0
M 08F3 0
M 0AE4 0
D 0000 0
M 0828 0
M 0CAB 0
M 0620 0
M 6E72 0
M 0418 0
M 0546 0
M 0250 0
M 0305 0
M 0BF7 0
M 0184 0
M B009 0
D 0000 0
L 0000 0
D 0001 3
M 070C 2
D 0000 5
D 0000 0

//--- numbat_board.f
+incdir+design
design/chess_pkg.sv
design/board_state.sv
design/display_board.sv
design/numbat_board_top.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_top \
   -f numbat_board.f -Mdir obj_dir -o tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" "$log"; then
   exit 1
fi
if ! grep -q "Simulation passed" "$log"; then
   echo "no pass line found in $log"
   exit 1
fi
exit 0
